// ==== lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

    //------------------------------------------------------------
    // Widths and pixel format
    //------------------------------------------------------------

    localparam int COORD_W = 12;  // Up to 4095 pixels per axis

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // Timing word passed between pipeline stages
    typedef struct packed {
        logic               de;    // Active high
        logic               hs_n;
        logic               vs_n;
        logic [COORD_W-1:0] x;     // Visible column, 0 in blanking
        logic [COORD_W-1:0] y;     // Visible row, 0 in blanking
    } lcd_timing_t;

    typedef enum logic {
        PAT_COLORBAR = 1'b0,
        PAT_CHECKER  = 1'b1
    } pattern_e;

    localparam lcd_timing_t TIMING_IDLE = '{de: 1'b0, hs_n: 1'b1, vs_n: 1'b1, x: '0, y: '0};

    localparam rgb565_t RGB_BLACK = '{r: 5'h00, g: 6'h00, b: 5'h00};
    localparam rgb565_t RGB_WHITE = '{r: 5'h1f, g: 6'h3f, b: 5'h1f};

    //------------------------------------------------------------
    // Default 480x272 panel geometry
    //------------------------------------------------------------

    localparam int DEF_H_VALID = 480;
    localparam int DEF_H_FP    = 50;
    localparam int DEF_H_BP    = 30;
    localparam int DEF_H_SYNC  = 4;   // Inside the back porch

    localparam int DEF_V_VALID = 272;
    localparam int DEF_V_FP    = 20;
    localparam int DEF_V_BP    = 5;
    localparam int DEF_V_SYNC  = 2;

endpackage

`default_nettype wire

// ==== lcd_sync_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module lcd_sync_gen
    import lcd_pkg::*;
#(
    parameter int H_VALID = 480,
    parameter int H_FP    = 50,
    parameter int H_BP    = 30,
    parameter int H_SYNC  = 4,
    parameter int V_VALID = 272,
    parameter int V_FP    = 20,
    parameter int V_BP    = 5,
    parameter int V_SYNC  = 2
) (
    input  logic        PixelClk,
    input  logic        nRST,
    output lcd_timing_t o_timing,
    output logic        o_frame_start
);

    // Line is BP, then visible, then FP; sync sits at the start of BP
    localparam int H_TOTAL = H_BP + H_VALID + H_FP;
    localparam int V_TOTAL = V_BP + V_VALID + V_FP;

    localparam logic [COORD_W-1:0] H_LAST     = COORD_W'(H_TOTAL - 1);
    localparam logic [COORD_W-1:0] V_LAST     = COORD_W'(V_TOTAL - 1);
    localparam logic [COORD_W-1:0] H_DE_START = COORD_W'(H_BP);
    localparam logic [COORD_W-1:0] H_DE_END   = COORD_W'(H_BP + H_VALID - 1);
    localparam logic [COORD_W-1:0] V_DE_START = COORD_W'(V_BP);
    localparam logic [COORD_W-1:0] V_DE_END   = COORD_W'(V_BP + V_VALID - 1);
    localparam logic [COORD_W-1:0] H_SYNC_END = COORD_W'(H_SYNC);
    localparam logic [COORD_W-1:0] V_SYNC_END = COORD_W'(V_SYNC);

    logic [COORD_W-1:0] h_cnt;
    logic [COORD_W-1:0] v_cnt;

    logic h_wrap;
    logic v_wrap;
    logic h_act;
    logic v_act;
    logic de_next;

    //------------------------------------------------------------
    // Free-running counters
    //------------------------------------------------------------

    assign h_wrap = (h_cnt == H_LAST);
    assign v_wrap = (v_cnt == V_LAST);

    always_ff @(posedge PixelClk or negedge nRST) begin
        if (!nRST) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_wrap) begin
                h_cnt <= '0;
                // Vertical only moves at end of line
                if (v_wrap) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    //------------------------------------------------------------
    // Decode and register timing word
    //------------------------------------------------------------

    assign h_act   = (h_cnt >= H_DE_START) && (h_cnt <= H_DE_END);
    assign v_act   = (v_cnt >= V_DE_START) && (v_cnt <= V_DE_END);
    assign de_next = h_act && v_act;

    always_ff @(posedge PixelClk or negedge nRST) begin
        if (!nRST) begin
            o_timing      <= TIMING_IDLE;
            o_frame_start <= 1'b0;
        end else begin
            o_timing.de   <= de_next;
            o_timing.hs_n <= (h_cnt >= H_SYNC_END);  // Low for first H_SYNC counts
            o_timing.vs_n <= (v_cnt >= V_SYNC_END);

            // Coordinates held at 0 outside the visible area
            if (de_next) begin
                o_timing.x <= h_cnt - H_DE_START;
                o_timing.y <= v_cnt - V_DE_START;
            end else begin
                o_timing.x <= '0;
                o_timing.y <= '0;
            end

            o_frame_start <= (h_cnt == '0) && (v_cnt == '0);
        end
    end

endmodule

`default_nettype wire

// ==== lcd_pattern_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module lcd_pattern_gen
    import lcd_pkg::*;
#(
    parameter int H_VALID = 480
) (
    input  logic        PixelClk,
    input  logic        nRST,
    input  lcd_timing_t i_timing,
    input  logic        i_frame_start,
    input  pattern_e    i_pattern_sel,
    output lcd_timing_t o_timing,
    output logic        o_frame_start,
    output rgb565_t     o_pixel
);

    localparam int BAR_W = H_VALID / 16;  // 16 bars across the line

    pattern_e   pat_q;
    pattern_e   pat_cur;
    logic [3:0] bar_idx;
    rgb565_t    bar_px;
    rgb565_t    checker_px;
    rgb565_t    px_next;

    //------------------------------------------------------------
    // Pattern select, held for a whole frame
    //------------------------------------------------------------

    // New select takes effect on the strobe cycle itself
    assign pat_cur = i_frame_start ? i_pattern_sel : pat_q;

    //------------------------------------------------------------
    // Pixel generation
    //------------------------------------------------------------

    assign bar_idx = 4'(i_timing.x / COORD_W'(BAR_W));

    // One-hot bars: 5 red, 6 green, 5 blue
    always_comb begin
        bar_px = RGB_BLACK;
        if (bar_idx < 4'd5) begin
            bar_px.r = 5'd1 << bar_idx;
        end else if (bar_idx < 4'd11) begin
            bar_px.g = 6'd1 << (bar_idx - 4'd5);
        end else begin
            bar_px.b = 5'd1 << (bar_idx - 4'd11);
        end
    end

    // 8x8 squares
    assign checker_px = (i_timing.x[3] ^ i_timing.y[3]) ? RGB_WHITE : RGB_BLACK;

    always_comb begin
        if (!i_timing.de) begin
            px_next = RGB_BLACK;  // Blanking
        end else begin
            case (pat_cur)
                PAT_CHECKER: px_next = checker_px;
                default:     px_next = bar_px;
            endcase
        end
    end

    //------------------------------------------------------------
    // Output stage, timing delayed to match the pixel
    //------------------------------------------------------------

    always_ff @(posedge PixelClk or negedge nRST) begin
        if (!nRST) begin
            pat_q         <= PAT_COLORBAR;
            o_timing      <= TIMING_IDLE;
            o_frame_start <= 1'b0;
            o_pixel       <= RGB_BLACK;
        end else begin
            if (i_frame_start) begin
                pat_q <= i_pattern_sel;
            end
            o_timing      <= i_timing;
            o_frame_start <= i_frame_start;
            o_pixel       <= px_next;
        end
    end

endmodule

`default_nettype wire

// ==== lcd_panel_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module lcd_panel_top
    import lcd_pkg::*;
#(
    parameter int H_VALID = DEF_H_VALID,
    parameter int H_FP    = DEF_H_FP,
    parameter int H_BP    = DEF_H_BP,
    parameter int H_SYNC  = DEF_H_SYNC,
    parameter int V_VALID = DEF_V_VALID,
    parameter int V_FP    = DEF_V_FP,
    parameter int V_BP    = DEF_V_BP,
    parameter int V_SYNC  = DEF_V_SYNC
) (
    input  logic       PixelClk,
    input  logic       nRST,
    input  pattern_e   i_pattern_sel,
    output logic       o_lcd_de,
    output logic       o_lcd_hs,    // Active low
    output logic       o_lcd_vs,    // Active low
    output logic [4:0] o_lcd_r,
    output logic [5:0] o_lcd_g,
    output logic [4:0] o_lcd_b,
    output logic       o_frame_start
);

    lcd_timing_t sync_timing;     // From counters
    logic        sync_frame_start;
    lcd_timing_t pix_timing;      // Aligned with pix_rgb
    rgb565_t     pix_rgb;

    //------------------------------------------------------------
    // Timing generator
    //------------------------------------------------------------

    lcd_sync_gen #(
        .H_VALID (H_VALID),
        .H_FP    (H_FP),
        .H_BP    (H_BP),
        .H_SYNC  (H_SYNC),
        .V_VALID (V_VALID),
        .V_FP    (V_FP),
        .V_BP    (V_BP),
        .V_SYNC  (V_SYNC)
    ) lcd_sync_gen_inst (
        .PixelClk      (PixelClk),
        .nRST          (nRST),
        .o_timing      (sync_timing),
        .o_frame_start (sync_frame_start)
    );

    //------------------------------------------------------------
    // Pattern generator
    //------------------------------------------------------------

    lcd_pattern_gen #(
        .H_VALID (H_VALID)
    ) lcd_pattern_gen_inst (
        .PixelClk      (PixelClk),
        .nRST          (nRST),
        .i_timing      (sync_timing),
        .i_frame_start (sync_frame_start),
        .i_pattern_sel (i_pattern_sel),
        .o_timing      (pix_timing),
        .o_frame_start (o_frame_start),
        .o_pixel       (pix_rgb)
    );

    // Panel pins, all from registers
    assign o_lcd_de = pix_timing.de;
    assign o_lcd_hs = pix_timing.hs_n;
    assign o_lcd_vs = pix_timing.vs_n;
    assign o_lcd_r  = pix_rgb.r;
    assign o_lcd_g  = pix_rgb.g;
    assign o_lcd_b  = pix_rgb.b;

endmodule

`default_nettype wire

// ==== lcd_panel_sva.sv ====
`default_nettype none
`timescale 1ns/1ps

module lcd_panel_sva #(
    parameter int H_SYNC = 4
) (
    input logic       PixelClk,
    input logic       nRST,
    input logic       i_de,
    input logic       i_hs,            // Active low
    input logic       i_vs,            // Active low
    input logic [4:0] i_r,
    input logic [5:0] i_g,
    input logic [4:0] i_b,
    input logic       i_frame_start
);

    int   hs_low_len;    // Length of the current hs_n pulse
    logic rst_seen;      // A clock edge has passed under reset

    initial begin
        rst_seen = 1'b0;
    end

    always @(posedge PixelClk) begin
        rst_seen <= rst_seen | !nRST;
    end

    always @(posedge PixelClk or negedge nRST) begin
        if (!nRST) begin
            hs_low_len <= 0;
        end else if (!i_hs) begin
            hs_low_len <= hs_low_len + 1;
        end else begin
            hs_low_len <= 0;
        end
    end

    //------------------------------------------------------------
    // Output protocol
    //------------------------------------------------------------

    hs_width_chk: assert property (@(posedge PixelClk) disable iff (!nRST)
        (i_hs && hs_low_len > 0) |-> (hs_low_len == H_SYNC))
        else $error("hs_n low for %0d cycles, expected %0d", $sampled(hs_low_len), H_SYNC);

    // No visible pixel inside a sync pulse
    de_sync_chk: assert property (@(posedge PixelClk) disable iff (!nRST)
        i_de |-> (i_hs && i_vs))
        else $error("de high while a sync pulse is active");

    fs_pulse_chk: assert property (@(posedge PixelClk) disable iff (!nRST)
        i_frame_start |=> !i_frame_start)
        else $error("frame start strobe longer than one cycle");

    reset_idle_chk: assert property (@(posedge PixelClk)
        (!nRST && rst_seen) |->
            (!i_de && i_hs && i_vs && i_r == '0 && i_g == '0 && i_b == '0 && !i_frame_start))
        else $error("outputs not idle during reset");

endmodule

`default_nettype wire

// ==== tb_lcd_panel_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_lcd_panel_top
    import lcd_pkg::*;
();

    //------------------------------------------------------------
    // Small panel geometry and run limits
    //------------------------------------------------------------

    localparam int H_VALID = 32;   // Bar width of 2
    localparam int H_FP    = 4;
    localparam int H_BP    = 3;
    localparam int H_SYNC  = 2;
    localparam int V_VALID = 18;
    localparam int V_FP    = 2;
    localparam int V_BP    = 3;
    localparam int V_SYNC  = 1;

    localparam int H_TOTAL     = H_BP + H_VALID + H_FP;   // 39
    localparam int V_TOTAL     = V_BP + V_VALID + V_FP;   // 23
    localparam int FRAME_CYC   = H_TOTAL * V_TOTAL;       // 897
    localparam int PIX_FRAME   = H_VALID * V_VALID;
    localparam int TIMEOUT_CYC = 5 * FRAME_CYC + 20;
    localparam int CLK_HALF    = 20;
    localparam int RST_CYCLES  = 4;

    logic       PixelClk;
    logic       nRST;
    pattern_e   pattern_sel;
    logic       lcd_de;
    logic       lcd_hs;
    logic       lcd_vs;
    logic [4:0] lcd_r;
    logic [5:0] lcd_g;
    logic [4:0] lcd_b;
    logic       frame_start;

    // Reference model state
    int       rel_cnt;       // Saturating count of cycles since reset release
    logic     de_prev;
    logic     hs_prev;
    int       ref_x;
    int       ref_y;
    int       hs_gap;
    int       hs_cnt;
    int       fs_gap;
    int       fs_cnt;
    pattern_e sel_q;
    pattern_e frame_pat;     // Select that owns the current frame
    int       bar_px_cnt;
    int       chk_px_cnt;
    int       cyc_cnt = 0;

    rgb565_t  dut_rgb;
    rgb565_t  exp_rgb;

    lcd_panel_top #(
        .H_VALID (H_VALID),
        .H_FP    (H_FP),
        .H_BP    (H_BP),
        .H_SYNC  (H_SYNC),
        .V_VALID (V_VALID),
        .V_FP    (V_FP),
        .V_BP    (V_BP),
        .V_SYNC  (V_SYNC)
    ) lcd_panel_top_inst (
        .PixelClk      (PixelClk),
        .nRST          (nRST),
        .i_pattern_sel (pattern_sel),
        .o_lcd_de      (lcd_de),
        .o_lcd_hs      (lcd_hs),
        .o_lcd_vs      (lcd_vs),
        .o_lcd_r       (lcd_r),
        .o_lcd_g       (lcd_g),
        .o_lcd_b       (lcd_b),
        .o_frame_start (frame_start)
    );

    bind lcd_panel_top lcd_panel_sva #(
        .H_SYNC (H_SYNC)
    ) lcd_panel_sva_inst (
        .PixelClk      (PixelClk),
        .nRST          (nRST),
        .i_de          (o_lcd_de),
        .i_hs          (o_lcd_hs),
        .i_vs          (o_lcd_vs),
        .i_r           (o_lcd_r),
        .i_g           (o_lcd_g),
        .i_b           (o_lcd_b),
        .i_frame_start (o_frame_start)
    );

    //------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // One lit bit per bar across 5 red, 6 green and 5 blue bars
    function automatic rgb565_t bar_color(input int x);
        int      k;
        rgb565_t res;
        k   = x / (H_VALID / 16);
        res = '0;
        if (k < 5) begin
            res.r = 5'(1 << k);
        end else if (k < 11) begin
            res.g = 6'(1 << (k - 5));
        end else begin
            res.b = 5'(1 << (k - 11));
        end
        return res;
    endfunction

    function automatic rgb565_t checker_color(input int x, input int y);
        rgb565_t res;
        res = '0;
        if (((x >> 3) & 1) != ((y >> 3) & 1)) begin
            res = '{r: 5'h1f, g: 6'h3f, b: 5'h1f};
        end
        return res;
    endfunction

    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge PixelClk);
    endtask

    task automatic wait_frame_start();
        @(negedge PixelClk);
        while (!frame_start) begin
            @(negedge PixelClk);
        end
    endtask

    //------------------------------------------------------------
    // Clock, timeout and reference model
    //------------------------------------------------------------

    initial begin
        PixelClk = 1'b0;
        forever #(CLK_HALF) PixelClk = ~PixelClk;
    end

    always @(posedge PixelClk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT_CYC) begin
            abort_run($sformatf("timeout, frames not finished after %0d cycles", cyc_cnt));
        end
    end

    assign dut_rgb = {lcd_r, lcd_g, lcd_b};

    always_comb begin
        if (frame_pat == PAT_CHECKER) begin
            exp_rgb = checker_color(ref_x, ref_y);
        end else begin
            exp_rgb = bar_color(ref_x);
        end
    end

    // Coordinates rebuilt from de and vs_n edges only
    always @(posedge PixelClk or negedge nRST) begin
        if (!nRST) begin
            rel_cnt    <= 0;
            de_prev    <= 1'b0;
            hs_prev    <= 1'b1;
            ref_x      <= 0;
            ref_y      <= 0;
            hs_gap     <= 0;
            hs_cnt     <= 0;
            fs_gap     <= 0;
            fs_cnt     <= 0;
            sel_q      <= PAT_COLORBAR;
            frame_pat  <= PAT_COLORBAR;
            bar_px_cnt <= 0;
            chk_px_cnt <= 0;
        end else begin
            if (rel_cnt < 3) begin
                rel_cnt <= rel_cnt + 1;
            end
            de_prev <= lcd_de;
            hs_prev <= lcd_hs;
            ref_x   <= lcd_de ? ref_x + 1 : 0;
            if (!lcd_vs) begin
                ref_y <= 0;
            end else if (de_prev && !lcd_de) begin
                ref_y <= ref_y + 1;   // Line just ended
            end
            if (hs_prev && !lcd_hs) begin
                hs_gap <= 1;
                hs_cnt <= hs_cnt + 1;
            end else begin
                hs_gap <= hs_gap + 1;
            end
            // DUT latches the select one stage before the strobe reaches the pins
            sel_q <= pattern_sel;
            if (frame_start) begin
                fs_gap    <= 1;
                fs_cnt    <= fs_cnt + 1;
                frame_pat <= sel_q;
            end else begin
                fs_gap <= fs_gap + 1;
            end
            if (lcd_de && frame_pat == PAT_CHECKER) begin
                chk_px_cnt <= chk_px_cnt + 1;
            end else if (lcd_de) begin
                bar_px_cnt <= bar_px_cnt + 1;
            end
        end
    end

    //------------------------------------------------------------
    // Checks
    //------------------------------------------------------------

    first_fs_chk: assert property (@(posedge PixelClk) disable iff (!nRST)
        (rel_cnt == 2) |-> frame_start)
        else report_mismatch("o_frame_start", int'($sampled(frame_start)), 1);

    early_fs_chk: assert property (@(posedge PixelClk) disable iff (!nRST)
        (frame_start && fs_cnt == 0) |-> (rel_cnt == 2))
        else report_mismatch("cycles to first o_frame_start", $sampled(rel_cnt), 2);

    line_de_chk: assert property (@(posedge PixelClk) disable iff (!nRST)
        (de_prev && !lcd_de) |-> (ref_x == H_VALID))
        else report_mismatch("o_lcd_de cycles per line", $sampled(ref_x), H_VALID);

    frame_lines_chk: assert property (@(posedge PixelClk) disable iff (!nRST)
        (frame_start && fs_cnt > 0) |-> (ref_y == V_VALID))
        else report_mismatch("o_lcd_de lines per frame", $sampled(ref_y), V_VALID);

    hs_period_chk: assert property (@(posedge PixelClk) disable iff (!nRST)
        (hs_prev && !lcd_hs && hs_cnt > 0) |-> (hs_gap == H_TOTAL))
        else report_mismatch("o_lcd_hs period", $sampled(hs_gap), H_TOTAL);

    fs_period_chk: assert property (@(posedge PixelClk) disable iff (!nRST)
        (frame_start && fs_cnt > 0) |-> (fs_gap == FRAME_CYC))
        else report_mismatch("o_frame_start period", $sampled(fs_gap), FRAME_CYC);

    pixel_chk: assert property (@(posedge PixelClk) disable iff (!nRST)
        lcd_de |-> (dut_rgb == exp_rgb))
        else report_mismatch("o_lcd_r/g/b", int'($sampled(dut_rgb)), int'($sampled(exp_rgb)));

    blank_chk: assert property (@(posedge PixelClk) disable iff (!nRST)
        !lcd_de |-> (dut_rgb == '0))
        else report_mismatch("o_lcd_r/g/b in blanking", int'($sampled(dut_rgb)), 0);

    //------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------

    initial begin
        logic [31:0] rng;
        int          offset;
        nRST        = 1'b0;
        pattern_sel = PAT_COLORBAR;
        rng         = 32'd16671;
        repeat (RST_CYCLES) @(negedge PixelClk);
        nRST = 1'b1;

        wait_frame_start();            // Frame 1 shows colour bars
        wait_cycles(FRAME_CYC - 20);
        pattern_sel = PAT_CHECKER;     // Front porch of frame 1

        wait_frame_start();            // Frame 2 shows the checkerboard
        wait_cycles(FRAME_CYC - 20);
        pattern_sel = PAT_COLORBAR;

        // Frame 3 starts with bars and the select flips in the visible area
        wait_frame_start();
        rng    = xorshift32(rng);
        offset = 150 + int'(rng % 32'd600);
        wait_cycles(offset);
        pattern_sel = PAT_CHECKER;

        wait_frame_start();            // Frame 4 shows the checkerboard
        wait_frame_start();            // Frame 5 start closes frame 4
        wait_cycles(4);

        if (fs_cnt < 5 || bar_px_cnt != 2 * PIX_FRAME || chk_px_cnt != 2 * PIX_FRAME) begin
            abort_run("not every frame was checked with its expected pattern");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
lcd_pkg.sv
lcd_sync_gen.sv
lcd_pattern_gen.sv
lcd_panel_top.sv
lcd_panel_sva.sv
tb_lcd_panel_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_lcd_panel_top
FILELIST  := all.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: sim clean

# Build, run, then judge the run from its log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
